//--- rtl/forth_isa_pkg.sv
`default_nettype none

package forth_isa_pkg;

	// Core sizing
	localparam int DATA_W  = 32;
	localparam int CODE_AW = 8;

	// Stack and code word, code address
	typedef logic [DATA_W-1:0]  word_t;
	typedef logic [CODE_AW-1:0] code_addr_t;

	// Forth flag values
	localparam word_t FLAG_TRUE  = '1;
	localparam word_t FLAG_FALSE = '0;

	// Token value of each opcode is its position in this list
	typedef enum logic [15:0] {
		OP_LIT,
		OP_DUP,
		OP_DROP,
		OP_OVER,
		OP_PLUS,
		OP_MINUS,
		OP_ONE_PLUS,
		OP_AND,
		OP_OR,
		OP_NOT,
		OP_NEGATE,
		OP_EQUAL,
		OP_ZERO_EQUAL,
		OP_ZERO_LESS,
		OP_BRANCH,
		OP_ZERO_BRANCH,
		OP_CALL,
		OP_EXIT,
		OP_EMIT,
		OP_IO_LED,
		OP_IO_BUTTON
	} op_e;

	// Inner interpreter states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_EXEC,
		ST_OPERAND,
		ST_EMIT
	} seq_state_e;

endpackage

`default_nettype wire

//--- rtl/forth_io_pkg.sv
`default_nettype none

package forth_io_pkg;

	// Host load port into code RAM
	typedef struct packed {
		logic                      en;
		forth_isa_pkg::code_addr_t addr;
		forth_isa_pkg::word_t      data;
	} code_wr_t;

	// One byte to the serial transmitter
	typedef struct packed {
		logic       send;
		logic [7:0] data;
	} uart_req_t;

	// Board pins, LEDs active low
	typedef struct packed {
		logic g;
		logic b;
		logic r;
	} led_t;

	typedef struct packed {
		logic b0;
		logic b1;
	} button_t;

endpackage

`default_nettype wire

//--- rtl/forth_alu.sv
`timescale 1ns/100ps
`default_nettype none

module forth_alu (
	input  wire forth_isa_pkg::op_e   i_op,
	input  wire forth_isa_pkg::word_t i_tos,
	input  wire forth_isa_pkg::word_t i_nos,
	output forth_isa_pkg::word_t      o_result
);

	// Second is the left operand, as in Forth
	always_comb begin
		case (i_op)
			forth_isa_pkg::OP_PLUS:     o_result = i_nos + i_tos;
			forth_isa_pkg::OP_MINUS:    o_result = i_nos - i_tos;
			forth_isa_pkg::OP_ONE_PLUS: o_result = i_tos + 1'b1;
			forth_isa_pkg::OP_AND:      o_result = i_nos & i_tos;
			forth_isa_pkg::OP_OR:       o_result = i_nos | i_tos;
			forth_isa_pkg::OP_NOT:      o_result = ~i_tos;
			forth_isa_pkg::OP_NEGATE:   o_result = ~i_tos + 1'b1;
			// Comparisons give all ones or zero
			forth_isa_pkg::OP_EQUAL: begin
				o_result = (i_nos == i_tos) ? forth_isa_pkg::FLAG_TRUE :
					forth_isa_pkg::FLAG_FALSE;
			end
			forth_isa_pkg::OP_ZERO_EQUAL: begin
				o_result = (i_tos == '0) ? forth_isa_pkg::FLAG_TRUE :
					forth_isa_pkg::FLAG_FALSE;
			end
			forth_isa_pkg::OP_ZERO_LESS: begin
				o_result = ($signed(i_tos) < 0) ? forth_isa_pkg::FLAG_TRUE :
					forth_isa_pkg::FLAG_FALSE;
			end
			default: o_result = i_tos;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/forth_stack.sv
`timescale 1ns/100ps
`default_nettype none

module forth_stack #(
	parameter int DEPTH = 16
) (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       i_push,
	input  wire                       i_pop,
	input  wire forth_isa_pkg::word_t i_wdata,
	output forth_isa_pkg::word_t      o_top
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

	forth_isa_pkg::word_t mem [DEPTH];
	logic [PTR_W-1:0]     ptr_q;
	logic [PTR_W-1:0]     ptr_inc;
	logic [PTR_W-1:0]     ptr_dec;

	// Circular pointer, wraps at DEPTH
	assign ptr_inc = (ptr_q == PTR_LAST) ? '0 : ptr_q + 1'b1;
	assign ptr_dec = (ptr_q == '0) ? PTR_LAST : ptr_q - 1'b1;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ptr_q <= '0;
		end else if (i_push && !i_pop) begin
			ptr_q <= ptr_inc;
		end else if (i_pop && !i_push) begin
			ptr_q <= ptr_dec;
		end
	end

	// Push writes above the pointer, push with pop replaces the entry
	always_ff @(posedge clk) begin
		if (i_push && i_pop) begin
			mem[ptr_q] <= i_wdata;
		end else if (i_push) begin
			mem[ptr_inc] <= i_wdata;
		end
	end

	assign o_top = mem[ptr_q];

endmodule

`default_nettype wire

//--- rtl/forth_code_ram.sv
`timescale 1ns/100ps
`default_nettype none

module forth_code_ram (
	input  wire                            clk,
	input  wire forth_io_pkg::code_wr_t    i_load,
	input  wire forth_isa_pkg::code_addr_t i_rd_addr,
	output forth_isa_pkg::word_t           o_rd_data
);

	localparam int WORDS = 2 ** forth_isa_pkg::CODE_AW;

	forth_isa_pkg::word_t mem [WORDS];

	// Host write port
	always_ff @(posedge clk) begin
		if (i_load.en) begin
			mem[i_load.addr] <= i_load.data;
		end
	end

	// Registered read, data one cycle after address
	always_ff @(posedge clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 625
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire forth_io_pkg::uart_req_t i_req,
	output logic                         o_busy,
	output logic                         o_tx
);

	localparam int BAUD_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);

	logic [BAUD_W-1:0] baud_q;
	logic [3:0]        bit_q;
	// Stop, data LSB first, start; bit 0 is on the line
	logic [9:0]        frame_q;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			o_busy  <= 1'b0;
			baud_q  <= '0;
			bit_q   <= '0;
			frame_q <= '1;
		end else if (!o_busy) begin
			// Latch a new byte
			if (i_req.send) begin
				o_busy  <= 1'b1;
				baud_q  <= '0;
				bit_q   <= '0;
				frame_q <= {1'b1, i_req.data, 1'b0};
			end
		end else if (baud_q == BAUD_LAST) begin
			// End of a bit period, shift in idle ones
			baud_q  <= '0;
			frame_q <= {1'b1, frame_q[9:1]};
			if (bit_q == 4'd9) begin
				o_busy <= 1'b0;
			end else begin
				bit_q <= bit_q + 1'b1;
			end
		end else begin
			baud_q <= baud_q + 1'b1;
		end
	end

	// Frame drains to all ones, so the line idles high
	assign o_tx = frame_q[0];

endmodule

`default_nettype wire

//--- rtl/forth_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module forth_sequencer (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              i_run,
	output forth_isa_pkg::code_addr_t        o_code_addr,
	input  wire forth_isa_pkg::word_t        i_code_data,
	output logic                             o_d_push,
	output logic                             o_d_pop,
	output forth_isa_pkg::word_t             o_d_wdata,
	input  wire forth_isa_pkg::word_t        i_d_second,
	output logic                             o_r_push,
	output logic                             o_r_pop,
	output forth_isa_pkg::word_t             o_r_wdata,
	input  wire forth_isa_pkg::word_t        i_r_top,
	output forth_isa_pkg::op_e               o_op,
	output forth_isa_pkg::word_t             o_tos,
	input  wire forth_isa_pkg::word_t        i_alu_result,
	output forth_io_pkg::uart_req_t          o_uart,
	input  wire                              i_uart_busy,
	input  wire forth_io_pkg::button_t       i_buttons,
	output forth_io_pkg::led_t               o_leds,
	output logic                             o_running
);

	localparam int DATA_W  = forth_isa_pkg::DATA_W;
	localparam int CODE_AW = forth_isa_pkg::CODE_AW;
	localparam int OP_W    = $bits(forth_isa_pkg::op_e);

	forth_isa_pkg::seq_state_e state_q, state_n;
	forth_isa_pkg::code_addr_t pc_q, pc_n;
	forth_isa_pkg::word_t      tos_q, tos_n;
	forth_isa_pkg::op_e        op_q, op_n;
	forth_io_pkg::led_t        led_q, led_n;
	logic                      sent_q, sent_n;
	logic                      uart_send;
	forth_isa_pkg::op_e        cur_op;
	forth_isa_pkg::word_t      call_target;

	// ------------------------------------------------------------------
	// Decode, sign bit marks a call to the negated token
	// ------------------------------------------------------------------
	assign cur_op = i_code_data[DATA_W-1] ? forth_isa_pkg::OP_CALL :
		forth_isa_pkg::op_e'(i_code_data[OP_W-1:0]);
	assign call_target = forth_isa_pkg::word_t'(0) - i_code_data;

	// Fixed datapath hookups
	assign o_code_addr = pc_q;
	assign o_op        = cur_op;
	assign o_tos       = tos_q;
	assign o_d_wdata   = tos_q;
	// Return address already points past the call token
	assign o_r_wdata   = {{(DATA_W-CODE_AW){1'b0}}, pc_q};
	assign o_uart      = '{send: uart_send, data: tos_q[7:0]};
	assign o_leds      = led_q;
	assign o_running   = (state_q != forth_isa_pkg::ST_IDLE);

	// ------------------------------------------------------------------
	// Next state and stack strobes
	// ------------------------------------------------------------------
	always_comb begin
		state_n   = state_q;
		pc_n      = pc_q;
		tos_n     = tos_q;
		op_n      = op_q;
		led_n     = led_q;
		sent_n    = sent_q;
		o_d_push  = 1'b0;
		o_d_pop   = 1'b0;
		o_r_push  = 1'b0;
		o_r_pop   = 1'b0;
		uart_send = 1'b0;
		if (!i_run) begin
			// Stopped, restart from address 0
			state_n = forth_isa_pkg::ST_IDLE;
			pc_n    = '0;
		end else begin
			case (state_q)
				forth_isa_pkg::ST_IDLE: state_n = forth_isa_pkg::ST_FETCH;
				forth_isa_pkg::ST_FETCH: begin
					// RAM samples pc this cycle
					pc_n    = pc_q + 1'b1;
					state_n = forth_isa_pkg::ST_EXEC;
				end
				forth_isa_pkg::ST_EXEC: begin
					op_n    = cur_op;
					state_n = forth_isa_pkg::ST_FETCH;
					case (cur_op)
						// Operand word follows the token
						forth_isa_pkg::OP_LIT,
						forth_isa_pkg::OP_BRANCH,
						forth_isa_pkg::OP_ZERO_BRANCH: begin
							pc_n    = pc_q + 1'b1;
							state_n = forth_isa_pkg::ST_OPERAND;
						end
						forth_isa_pkg::OP_DUP: o_d_push = 1'b1;
						forth_isa_pkg::OP_DROP: begin
							tos_n   = i_d_second;
							o_d_pop = 1'b1;
						end
						forth_isa_pkg::OP_OVER: begin
							o_d_push = 1'b1;
							tos_n    = i_d_second;
						end
						// Binary ALU ops consume second
						forth_isa_pkg::OP_PLUS,
						forth_isa_pkg::OP_MINUS,
						forth_isa_pkg::OP_AND,
						forth_isa_pkg::OP_OR,
						forth_isa_pkg::OP_EQUAL: begin
							tos_n   = i_alu_result;
							o_d_pop = 1'b1;
						end
						forth_isa_pkg::OP_ONE_PLUS,
						forth_isa_pkg::OP_NOT,
						forth_isa_pkg::OP_NEGATE,
						forth_isa_pkg::OP_ZERO_EQUAL,
						forth_isa_pkg::OP_ZERO_LESS: tos_n = i_alu_result;
						forth_isa_pkg::OP_CALL: begin
							o_r_push = 1'b1;
							pc_n     = call_target[CODE_AW-1:0];
						end
						forth_isa_pkg::OP_EXIT: begin
							o_r_pop = 1'b1;
							pc_n    = i_r_top[CODE_AW-1:0];
						end
						forth_isa_pkg::OP_EMIT: begin
							sent_n  = 1'b0;
							state_n = forth_isa_pkg::ST_EMIT;
						end
						forth_isa_pkg::OP_IO_LED: begin
							led_n   = '{g: tos_q[0], b: tos_q[1], r: tos_q[2]};
							tos_n   = i_d_second;
							o_d_pop = 1'b1;
						end
						forth_isa_pkg::OP_IO_BUTTON: begin
							o_d_push = 1'b1;
							tos_n    = {{(DATA_W-2){1'b0}}, i_buttons.b1, i_buttons.b0};
						end
						default: ;
					endcase
				end
				forth_isa_pkg::ST_OPERAND: begin
					state_n = forth_isa_pkg::ST_FETCH;
					case (op_q)
						forth_isa_pkg::OP_LIT: begin
							o_d_push = 1'b1;
							tos_n    = i_code_data;
						end
						forth_isa_pkg::OP_BRANCH: pc_n = i_code_data[CODE_AW-1:0];
						forth_isa_pkg::OP_ZERO_BRANCH: begin
							// Flag is consumed either way
							if (tos_q == '0) begin
								pc_n = i_code_data[CODE_AW-1:0];
							end
							tos_n   = i_d_second;
							o_d_pop = 1'b1;
						end
						default: ;
					endcase
				end
				forth_isa_pkg::ST_EMIT: begin
					// Hand off once, then hold until the stop bit is out
					if (!i_uart_busy) begin
						if (!sent_q) begin
							uart_send = 1'b1;
							sent_n    = 1'b1;
						end else begin
							tos_n   = i_d_second;
							o_d_pop = 1'b1;
							state_n = forth_isa_pkg::ST_FETCH;
						end
					end
				end
				default: state_n = forth_isa_pkg::ST_IDLE;
			endcase
		end
	end

	// Control registers
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state_q <= forth_isa_pkg::ST_IDLE;
			pc_q    <= '0;
			led_q   <= '1;
			sent_q  <= 1'b0;
		end else begin
			state_q <= state_n;
			pc_q    <= pc_n;
			led_q   <= led_n;
			sent_q  <= sent_n;
		end
	end

	// Top of stack and latched opcode
	always_ff @(posedge clk) begin
		tos_q <= tos_n;
		op_q  <= op_n;
	end

endmodule

`default_nettype wire

//--- rtl/forth_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module forth_core_top #(
	parameter int DSTACK_DEPTH = 16,
	parameter int RSTACK_DEPTH = 8,
	parameter int CLKS_PER_BIT = 625
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire forth_io_pkg::code_wr_t  i_load,
	input  wire                          i_run,
	input  wire forth_io_pkg::button_t   i_buttons,
	output forth_io_pkg::led_t           o_leds,
	output logic                         o_tx,
	output logic                         o_running
);

	// Code fetch path
	forth_isa_pkg::code_addr_t code_addr;
	forth_isa_pkg::word_t      code_data;

	// Data stack, top lives in the sequencer
	logic                 d_push;
	logic                 d_pop;
	forth_isa_pkg::word_t d_wdata;
	forth_isa_pkg::word_t d_second;

	// Return stack
	logic                 r_push;
	logic                 r_pop;
	forth_isa_pkg::word_t r_wdata;
	forth_isa_pkg::word_t r_top;

	// ALU and UART
	forth_isa_pkg::op_e      alu_op;
	forth_isa_pkg::word_t    alu_tos;
	forth_isa_pkg::word_t    alu_result;
	forth_io_pkg::uart_req_t uart_req;
	logic                    uart_busy;

	forth_sequencer u_seq (
		.clk          (clk),
		.reset        (reset),
		.i_run        (i_run),
		.o_code_addr  (code_addr),
		.i_code_data  (code_data),
		.o_d_push     (d_push),
		.o_d_pop      (d_pop),
		.o_d_wdata    (d_wdata),
		.i_d_second   (d_second),
		.o_r_push     (r_push),
		.o_r_pop      (r_pop),
		.o_r_wdata    (r_wdata),
		.i_r_top      (r_top),
		.o_op         (alu_op),
		.o_tos        (alu_tos),
		.i_alu_result (alu_result),
		.o_uart       (uart_req),
		.i_uart_busy  (uart_busy),
		.i_buttons    (i_buttons),
		.o_leds       (o_leds),
		.o_running    (o_running)
	);

	forth_code_ram u_code_ram (
		.clk       (clk),
		.i_load    (i_load),
		.i_rd_addr (code_addr),
		.o_rd_data (code_data)
	);

	forth_stack #(.DEPTH(DSTACK_DEPTH)) u_dstack (
		.clk     (clk),
		.reset   (reset),
		.i_push  (d_push),
		.i_pop   (d_pop),
		.i_wdata (d_wdata),
		.o_top   (d_second)
	);

	forth_stack #(.DEPTH(RSTACK_DEPTH)) u_rstack (
		.clk     (clk),
		.reset   (reset),
		.i_push  (r_push),
		.i_pop   (r_pop),
		.i_wdata (r_wdata),
		.o_top   (r_top)
	);

	forth_alu u_alu (
		.i_op     (alu_op),
		.i_tos    (alu_tos),
		.i_nos    (d_second),
		.o_result (alu_result)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
		.clk    (clk),
		.reset  (reset),
		.i_req  (uart_req),
		.o_busy (uart_busy),
		.o_tx   (o_tx)
	);

endmodule

`default_nettype wire

//--- dv/forth_props.sv
`timescale 1ns/100ps
`default_nettype none

module forth_props #(
	parameter bit SEQ_SIDE = 1'b1
) (
	input wire                            clk,
	input wire                            reset,
	input wire                            i_run,
	input wire forth_isa_pkg::seq_state_e i_state,
	input wire                            i_send,
	input wire                            i_busy,
	input wire                            i_tx
);

	if (SEQ_SIDE) begin : g_seq

		// ------------------------------------------------------------------
		// UART handoff and run control
		// ------------------------------------------------------------------

		// Strobe only into an idle transmitter
		send_only_when_idle: assert property (
			@(posedge clk) disable iff (!reset) i_send |-> !i_busy
		) else $error("send strobe raised while uart busy");

		// State register follows run one cycle later
		idle_when_stopped: assert property (
			@(posedge clk) disable iff (!reset)
				!i_run |=> (i_state == forth_isa_pkg::ST_IDLE)
		) else $error("sequencer left idle while run is low");

	end else begin : g_tx

		// ------------------------------------------------------------------
		// Serial line
		// ------------------------------------------------------------------

		// Line idles high between frames
		tx_high_when_idle: assert property (
			@(posedge clk) disable iff (!reset) !i_busy |-> i_tx
		) else $error("tx line low while uart not busy");

	end

endmodule

// Serial line lives in uart_tx so tx is tied off here
bind forth_sequencer forth_props #(.SEQ_SIDE(1'b1)) u_seq_props (
	.clk     (clk),
	.reset   (reset),
	.i_run   (i_run),
	.i_state (state_q),
	.i_send  (o_uart.send),
	.i_busy  (i_uart_busy),
	.i_tx    (1'b1)
);

// Only the line check runs on the transmitter
bind uart_tx forth_props #(.SEQ_SIDE(1'b0)) u_tx_props (
	.clk     (clk),
	.reset   (reset),
	.i_run   (1'b1),
	.i_state (forth_isa_pkg::ST_IDLE),
	.i_send  (i_req.send),
	.i_busy  (o_busy),
	.i_tx    (o_tx)
);

`default_nettype wire

//--- dv/tb_forth.sv
`timescale 1ns/100ps
`default_nettype none

module tb_forth;

	localparam int CPB             = 8;
	localparam int RESET_CYCLES    = 4;
	localparam int N_LIT_BYTES     = 6;
	localparam int N_ALU_CASES     = 14;
	localparam int N_LOOP_BYTES    = 15;
	localparam int N_CALL_BYTES    = 3;
	localparam int TOTAL_BYTES     = N_LIT_BYTES + N_ALU_CASES + N_LOOP_BYTES + N_CALL_BYTES;
	// Twice a frame per byte, plus load and setup slack
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 10 * CPB * 2 + 2000;
	localparam int RX_WAIT_CYCLES  = 10 * CPB * 2 + 200;
	localparam int LED_WAIT_CYCLES = 100;
	localparam int SEED            = 32'h887b_8c7f;

	logic                   clk = 1'b0;
	logic                   reset;
	forth_io_pkg::code_wr_t load;
	logic                   run;
	forth_io_pkg::button_t  buttons;
	forth_io_pkg::led_t     leds;
	logic                   tx;
	logic                   running;

	// Program image built by each test
	forth_isa_pkg::word_t prog_q[$];
	int unsigned          n_checks;
	int unsigned          n_errors;

	always #5 clk = ~clk;

	forth_core_top #(
		.DSTACK_DEPTH (16),
		.RSTACK_DEPTH (8),
		.CLKS_PER_BIT (CPB)
	) dut (
		.clk       (clk),
		.reset     (reset),
		.i_load    (load),
		.i_run     (run),
		.i_buttons (buttons),
		.o_leds    (leds),
		.o_tx      (tx),
		.o_running (running)
	);

	// ------------------------------------------------------------------
	// Program building
	// ------------------------------------------------------------------

	// Token value is the opcode's position in the list
	function automatic void add_token(input forth_isa_pkg::op_e op);
		prog_q.push_back(forth_isa_pkg::word_t'(op));
	endfunction

	function automatic void add_literal(input forth_isa_pkg::word_t value);
		add_token(forth_isa_pkg::OP_LIT);
		prog_q.push_back(value);
	endfunction

	// Negated address, sign bit marks the call
	function automatic forth_isa_pkg::word_t call_token(input int target);
		return forth_isa_pkg::word_t'(0) - forth_isa_pkg::word_t'(target);
	endfunction

	// Branch to itself so the core parks
	function automatic void park_loop();
		int here;
		here = prog_q.size();
		add_token(forth_isa_pkg::OP_BRANCH);
		prog_q.push_back(forth_isa_pkg::word_t'(here));
	endfunction

	// ------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------

	task automatic check_byte(input logic [7:0] got, input logic [7:0] want, input string what);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("** Error @ %0t: %s: got 8'h%02h, expected 8'h%02h",
				$time, what, got, want);
		end
	endtask

	task automatic check_leds(input forth_io_pkg::led_t got, input forth_io_pkg::led_t want,
		input string what);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("** Error @ %0t: %s: got g=%b b=%b r=%b, expected g=%b b=%b r=%b",
				$time, what, got.g, got.b, got.r, want.g, want.b, want.r);
		end
	endtask

	task automatic check_word(input forth_isa_pkg::word_t got, input forth_isa_pkg::word_t want,
		input string what);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("** Error @ %0t: %s: got 32'h%08h, expected 32'h%08h",
				$time, what, got, want);
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("** Error @ %0t: %s: got %b, expected %b", $time, what, got, want);
		end
	endtask

	// ------------------------------------------------------------------
	// Load port and serial decoder
	// ------------------------------------------------------------------

	// Stop the core, write the image from address 0, restart
	task automatic load_and_run();
		int i;
		@(posedge clk);
		run <= 1'b0;
		for (i = 0; i < prog_q.size(); i++) begin
			@(posedge clk);
			load <= '{en: 1'b1, addr: forth_isa_pkg::code_addr_t'(i), data: prog_q[i]};
		end
		@(posedge clk);
		load <= '0;
		run  <= 1'b1;
	endtask

	// 8N1 frame, sampled mid bit on the falling clock
	task automatic receive_byte(output logic [7:0] data, output bit got, input string what);
		int waited;
		int i;
		data   = '0;
		got    = 1'b0;
		waited = 0;
		@(negedge clk);
		while (tx !== 1'b0 && waited < RX_WAIT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (tx !== 1'b0) begin
			n_errors++;
			$display("no byte received on tx at %0t, waiting for %s", $time, what);
		end else begin
			repeat (CPB / 2) @(negedge clk);
			if (tx !== 1'b0) begin
				n_errors++;
				$display("start bit on tx ended early at %0t for %s", $time, what);
			end
			// LSB first
			for (i = 0; i < 8; i++) begin
				repeat (CPB) @(negedge clk);
				data[i] = tx;
			end
			repeat (CPB) @(negedge clk);
			if (tx !== 1'b1) begin
				n_errors++;
				$display("stop bit on tx not high at %0t for %s", $time, what);
			end
			got = 1'b1;
		end
	endtask

	task automatic expect_tx_byte(input logic [7:0] want, input string what);
		logic [7:0] data;
		bit         got;
		receive_byte(data, got, what);
		if (got) begin
			check_byte(data, want, what);
		end
	endtask

	// ------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------

	task automatic reset_defaults();
		@(negedge clk);
		check_bit(tx, 1'b1, "tx level after reset");
		check_leds(leds, forth_io_pkg::led_t'('1), "leds after reset");
		check_bit(running, 1'b0, "running after reset");
		check_bit(dut.uart_req.send, 1'b0, "send strobe after reset");
		check_word(forth_isa_pkg::word_t'(dut.u_dstack.ptr_q), '0, "data stack pointer after reset");
		check_word(forth_isa_pkg::word_t'(dut.u_rstack.ptr_q), '0, "return stack pointer after reset");
	endtask

	task automatic literal_emit();
		logic [7:0] bytes [N_LIT_BYTES];
		int         i;
		prog_q.delete();
		for (i = 0; i < N_LIT_BYTES; i++) begin
			bytes[i] = 8'($urandom());
			add_literal(forth_isa_pkg::word_t'(bytes[i]));
			add_token(forth_isa_pkg::OP_EMIT);
		end
		park_loop();
		load_and_run();
		for (i = 0; i < N_LIT_BYTES; i++) begin
			expect_tx_byte(bytes[i], $sformatf("literal byte %0d", i));
		end
	endtask

	// Second literal a is below top literal b
	task automatic stack_alu_ops();
		forth_isa_pkg::word_t a;
		forth_isa_pkg::word_t b;
		forth_isa_pkg::word_t want;
		int                   idx;
		for (idx = 0; idx < N_ALU_CASES; idx++) begin
			a = $urandom();
			b = $urandom();
			prog_q.delete();
			add_literal(a);
			add_literal(b);
			case (idx)
				0: begin
					add_token(forth_isa_pkg::OP_PLUS);
					want = a + b;
				end
				1: begin
					add_token(forth_isa_pkg::OP_MINUS);
					want = a - b;
				end
				2: begin
					add_token(forth_isa_pkg::OP_AND);
					want = a & b;
				end
				3: begin
					add_token(forth_isa_pkg::OP_OR);
					want = a | b;
				end
				4: begin
					add_token(forth_isa_pkg::OP_NOT);
					want = ~b;
				end
				5: begin
					add_token(forth_isa_pkg::OP_NEGATE);
					want = 32'd0 - b;
				end
				6: begin
					add_token(forth_isa_pkg::OP_ONE_PLUS);
					want = b + 32'd1;
				end
				7: begin
					add_token(forth_isa_pkg::OP_EQUAL);
					want = (a == b) ? forth_isa_pkg::FLAG_TRUE : forth_isa_pkg::FLAG_FALSE;
				end
				8: begin
					add_token(forth_isa_pkg::OP_DUP);
					add_token(forth_isa_pkg::OP_PLUS);
					want = b + b;
				end
				9: begin
					add_token(forth_isa_pkg::OP_DUP);
					add_token(forth_isa_pkg::OP_EQUAL);
					want = forth_isa_pkg::FLAG_TRUE;
				end
				10: begin
					add_token(forth_isa_pkg::OP_DROP);
					add_token(forth_isa_pkg::OP_ONE_PLUS);
					want = a + 32'd1;
				end
				// Copy of a lands on top
				11: begin
					add_token(forth_isa_pkg::OP_OVER);
					add_token(forth_isa_pkg::OP_MINUS);
					want = b - a;
				end
				12: begin
					add_token(forth_isa_pkg::OP_DUP);
					add_token(forth_isa_pkg::OP_MINUS);
					add_token(forth_isa_pkg::OP_ZERO_EQUAL);
					want = forth_isa_pkg::FLAG_TRUE;
				end
				default: begin
					add_token(forth_isa_pkg::OP_DROP);
					add_token(forth_isa_pkg::OP_ZERO_LESS);
					want = ($signed(a) < 0) ? forth_isa_pkg::FLAG_TRUE :
						forth_isa_pkg::FLAG_FALSE;
				end
			endcase
			add_token(forth_isa_pkg::OP_EMIT);
			park_loop();
			load_and_run();
			expect_tx_byte(want[7:0], $sformatf("stack/ALU case %0d", idx));
		end
	endtask

	// Emit n, n-1 .. 1 and leave on zero
	task automatic countdown_loop();
		int n;
		int k;
		int loop_at;
		int exit_slot;
		for (n = 1; n <= 5; n++) begin
			prog_q.delete();
			add_literal(forth_isa_pkg::word_t'(n));
			loop_at = prog_q.size();
			add_token(forth_isa_pkg::OP_DUP);
			add_token(forth_isa_pkg::OP_EMIT);
			add_literal(forth_isa_pkg::word_t'(1));
			add_token(forth_isa_pkg::OP_MINUS);
			add_token(forth_isa_pkg::OP_DUP);
			add_token(forth_isa_pkg::OP_ZERO_BRANCH);
			exit_slot = prog_q.size();
			prog_q.push_back('0);
			add_token(forth_isa_pkg::OP_BRANCH);
			prog_q.push_back(forth_isa_pkg::word_t'(loop_at));
			// Exit target is the park loop
			prog_q[exit_slot] = forth_isa_pkg::word_t'(prog_q.size());
			park_loop();
			load_and_run();
			for (k = n; k >= 1; k--) begin
				expect_tx_byte(8'(k), $sformatf("countdown from %0d, count %0d", n, k));
			end
		end
	endtask

	// Main emits first and third, subroutine emits second
	task automatic call_and_exit();
		logic [7:0]           bytes [N_CALL_BYTES];
		int                   call_slot;
		int                   i;
		forth_isa_pkg::word_t rptr_before;
		for (i = 0; i < N_CALL_BYTES; i++) begin
			bytes[i] = 8'($urandom());
		end
		prog_q.delete();
		add_literal(forth_isa_pkg::word_t'(bytes[0]));
		add_token(forth_isa_pkg::OP_EMIT);
		call_slot = prog_q.size();
		prog_q.push_back('0);
		add_literal(forth_isa_pkg::word_t'(bytes[2]));
		add_token(forth_isa_pkg::OP_EMIT);
		park_loop();
		prog_q[call_slot] = call_token(prog_q.size());
		add_literal(forth_isa_pkg::word_t'(bytes[1]));
		add_token(forth_isa_pkg::OP_EMIT);
		add_token(forth_isa_pkg::OP_EXIT);
		rptr_before = forth_isa_pkg::word_t'(dut.u_rstack.ptr_q);
		load_and_run();
		for (i = 0; i < N_CALL_BYTES; i++) begin
			expect_tx_byte(bytes[i], $sformatf("call/exit byte %0d", i));
		end
		@(negedge clk);
		check_word(forth_isa_pkg::word_t'(dut.u_rstack.ptr_q), rptr_before,
			"return stack pointer after exit");
	endtask

	// io_button pushes {b1, b0}, io_led drives g, b, r from bits 0..2
	task automatic buttons_to_leds();
		forth_io_pkg::button_t btn;
		forth_io_pkg::led_t    want;
		int                    waited;
		btn  = forth_io_pkg::button_t'(2'($urandom()));
		want = '{g: btn.b0, b: btn.b1, r: 1'b0};
		@(posedge clk);
		buttons <= btn;
		prog_q.delete();
		add_token(forth_isa_pkg::OP_IO_BUTTON);
		add_token(forth_isa_pkg::OP_IO_LED);
		park_loop();
		load_and_run();
		waited = 0;
		@(negedge clk);
		while (leds.r !== 1'b0 && waited < LED_WAIT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (leds.r !== 1'b0) begin
			n_errors++;
			$display("leds never updated by io_led at %0t", $time);
		end
		check_leds(leds, want, "leds from buttons");
		check_bit(running, 1'b1, "running while program runs");
	endtask

	// ------------------------------------------------------------------
	// Sequence and summary
	// ------------------------------------------------------------------

	initial begin
		void'($urandom(SEED));
		n_checks = 0;
		n_errors = 0;
		reset   <= 1'b0;
		run     <= 1'b0;
		load    <= '0;
		buttons <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b1;
		reset_defaults();
		literal_emit();
		stack_alu_ops();
		countdown_loop();
		call_and_exit();
		buttons_to_leds();
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Hard stop if the core or the decoder hangs
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
rtl/forth_isa_pkg.sv
rtl/forth_io_pkg.sv
rtl/forth_alu.sv
rtl/forth_stack.sv
rtl/forth_code_ram.sv
rtl/uart_tx.sv
rtl/forth_sequencer.sv
rtl/forth_core_top.sv
dv/forth_props.sv
dv/tb_forth.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_forth --Mdir "$OBJ" -o sim_forth -f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_forth" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
exit 0
